/* bench/tb_serial_bus.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_serial_bus;
	import serial_bus_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_OPS = 200;
	localparam int ACK_LIMIT = 200;
	localparam int WATCHDOG_NS = 2 * NUM_OPS * 60 * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset;
	logic m0_req;
	logic m0_write;
	addr_t m0_addr;
	data_t m0_wdata;
	logic m0_ack;
	data_t m0_rdata;
	logic m1_req;
	logic m1_write;
	addr_t m1_addr;
	data_t m1_wdata;
	logic m1_ack;
	data_t m1_rdata;

	// Model indexed by address bit 11 and address bits 7:0.
	data_t model [NUM_SLAVES*MEM_DEPTH];
	logic known [NUM_SLAVES*MEM_DEPTH];

	logic [1:0] req_q;
	logic [1:0] ack_prev;
	int streak [2];

	serial_bus_top u_dut (
		.clk (clk),
		.reset (reset),
		.m0_req (m0_req),
		.m0_write (m0_write),
		.m0_addr (m0_addr),
		.m0_wdata (m0_wdata),
		.m0_ack (m0_ack),
		.m0_rdata (m0_rdata),
		.m1_req (m1_req),
		.m1_write (m1_write),
		.m1_addr (m1_addr),
		.m1_wdata (m1_wdata),
		.m1_ack (m1_ack),
		.m1_rdata (m1_rdata)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected)
			abort_run($sformatf("mismatch %s expected %02h actual %02h", name, expected, actual));
	endtask

	function automatic logic ack_of(input int m);
		return (m == 0) ? m0_ack : m1_ack;
	endfunction

	function automatic data_t rdata_of(input int m);
		return (m == 0) ? m0_rdata : m1_rdata;
	endfunction

	function automatic int model_index(input addr_t a);
		return int'({a[SEL_BIT], a[MEM_IDX_W-1:0]});
	endfunction

	// Waits at falling edges for ack to reach the given level.
	task automatic check_ack(input string name, input int m, input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (ack_of(m) !== level)
		begin
			if (cycles == limit)
				abort_run($sformatf("%s: ack did not go to %0d within %0d cycles",
					name, level, limit));
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic drive_request(input int m, input logic req, input logic wr,
		input addr_t a, input data_t d);
		if (m == 0)
		begin
			m0_req = req;
			m0_write = wr;
			m0_addr = a;
			m0_wdata = d;
		end
		else
		begin
			m1_req = req;
			m1_write = wr;
			m1_addr = a;
			m1_wdata = d;
		end
	endtask

	// One full four-phase request, checked against the model at the ack rise.
	task automatic run_op(input string test, input int m, input logic wr,
		input addr_t a, input data_t d);
		string name;
		int idx;
		name = $sformatf("%s m%0d %s %03h", test, m, wr ? "write" : "read", a);
		idx = model_index(a);
		drive_request(m, 1'b1, wr, a, d);
		check_ack(name, m, 1'b1, ACK_LIMIT);
		if (wr)
		begin
			model[idx] = d;
			known[idx] = 1'b1;
		end
		else if (known[idx])
			check_data(name, model[idx], rdata_of(m));
		drive_request(m, 1'b0, wr, a, d);
		check_ack(name, m, 1'b0, 2);
	endtask

	// Each master stays in its own slave, so the other cannot disturb its bytes.
	task automatic run_random(input int m);
		addr_t a;
		for (int i = 0; i < NUM_OPS; i++)
		begin
			a = addr_t'($urandom);
			a[SEL_BIT] = m[0];
			// Small index range so reads often hit written bytes.
			a[MEM_IDX_W-1:0] = {2'b00, 6'($urandom)};
			run_op("concurrent", m, 1'($urandom), a, data_t'($urandom));
			if ($urandom_range(3, 0) == 0)
				repeat ($urandom_range(4, 1)) @(negedge clk);
		end
	endtask

	// Requests as the DUT saw them at the rising edge.
	always @(posedge clk)
		req_q <= {m1_req, m0_req};

	task automatic note_ack(input int m);
		if (!req_q[m])
			abort_run($sformatf("ack of master %0d rose without a request", m));
		streak[1-m] = 0;
		if (req_q[1-m])
			streak[m] = streak[m] + 1;
		else
			streak[m] = 0;
		if (streak[m] > 2)
			abort_run($sformatf("master %0d finished %0d operations in a row while the other waited",
				m, streak[m]));
	endtask

	always @(negedge clk)
	begin
		if (reset)
			ack_prev = 2'b00;
		else
		begin
			if (m0_ack && !ack_prev[0])
				note_ack(0);
			if (m1_ack && !ack_prev[1])
				note_ack(1);
			ack_prev = {m1_ack, m0_ack};
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("timeout, the bus stopped completing requests");
	end

	initial
	begin
		void'($urandom(32'h3484));
		reset = 1'b1;
		drive_request(0, 1'b0, 1'b0, '0, '0);
		drive_request(1, 1'b0, 1'b0, '0, '0);
		streak[0] = 0;
		streak[1] = 0;
		for (int i = 0; i < NUM_SLAVES*MEM_DEPTH; i++)
		begin
			model[i] = '0;
			known[i] = 1'b0;
		end
		repeat (3) @(negedge clk);
		reset = 1'b0;
		// Idle bus, the monitor flags any ack.
		repeat (4) @(negedge clk);

		// Both slaves from one master, then aliases through bits 10:8.
		run_op("single", 0, 1'b1, 12'h0a5, 8'h3c);
		run_op("single", 0, 1'b1, 12'h8c1, 8'he7);
		run_op("single", 0, 1'b0, 12'h0a5, 8'h00);
		run_op("single", 0, 1'b0, 12'h8c1, 8'h00);
		run_op("alias", 0, 1'b0, 12'h5a5, 8'h00);
		run_op("alias", 1, 1'b0, 12'hbc1, 8'h00);

		fork
			run_random(0);
			run_random(1);
		join

		repeat (4) @(negedge clk);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
	input wire logic clk,
	input wire logic reset,
	input wire logic bus_req0,
	input wire logic bus_req1,
	output logic bus_gnt0,
	output logic bus_gnt1,
	serial_link_if.slave m_link0,
	serial_link_if.slave m_link1,
	serial_link_if.master s_link0,
	serial_link_if.master s_link1
);
	import serial_bus_pkg::*;

	// One-hot owner, all zero when the link is free.
	logic [NUM_MASTERS-1:0] gnt_q;
	logic last_served;

	logic valid;
	logic write_en;
	logic tx_address;
	logic tx_data;
	logic ready_all;
	logic rx_any;
	logic done_any;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			gnt_q <= '0;
			// Master 0 goes first after reset.
			last_served <= 1'b1;
		end
		else if (gnt_q == '0)
		begin
			if (bus_req0 && (!bus_req1 || last_served))
			begin
				gnt_q <= 2'b01;
				last_served <= 1'b0;
			end
			else if (bus_req1)
			begin
				gnt_q <= 2'b10;
				last_served <= 1'b1;
			end
		end
		else if ((gnt_q[0] && !bus_req0) || (gnt_q[1] && !bus_req1))
			gnt_q <= '0;
	end

	assign bus_gnt0 = gnt_q[0];
	assign bus_gnt1 = gnt_q[1];

	// Owner's request lines go to both slaves.
	assign valid = (gnt_q[0] & m_link0.valid) | (gnt_q[1] & m_link1.valid);
	assign write_en = (gnt_q[0] & m_link0.write_en) | (gnt_q[1] & m_link1.write_en);
	assign tx_address = (gnt_q[0] & m_link0.tx_address) | (gnt_q[1] & m_link1.tx_address);
	assign tx_data = (gnt_q[0] & m_link0.tx_data) | (gnt_q[1] & m_link1.tx_data);

	assign s_link0.valid = valid;
	assign s_link0.write_en = write_en;
	assign s_link0.tx_address = tx_address;
	assign s_link0.tx_data = tx_data;
	assign s_link1.valid = valid;
	assign s_link1.write_en = write_en;
	assign s_link1.tx_address = tx_address;
	assign s_link1.tx_data = tx_data;

	// Unselected slaves return zeros, so OR is enough.
	assign ready_all = s_link0.ready & s_link1.ready;
	assign rx_any = s_link0.rx_data | s_link1.rx_data;
	assign done_any = s_link0.done | s_link1.done;

	assign m_link0.ready = gnt_q[0] & ready_all;
	assign m_link0.rx_data = gnt_q[0] & rx_any;
	assign m_link0.done = gnt_q[0] & done_any;
	assign m_link1.ready = gnt_q[1] & ready_all;
	assign m_link1.rx_data = gnt_q[1] & rx_any;
	assign m_link1.done = gnt_q[1] & done_any;

endmodule

`default_nettype wire

/* hdl/master_port.sv */
`timescale 1ns/100ps
`default_nettype none

module master_port (
	input wire logic clk,
	input wire logic reset,
	input wire logic req,
	input wire logic write,
	input serial_bus_pkg::addr_t addr,
	input serial_bus_pkg::data_t wdata,
	output logic ack,
	output serial_bus_pkg::data_t rdata,
	output logic bus_req,
	input wire logic bus_gnt,
	serial_link_if.master link
);
	import serial_bus_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		ARB,
		HANDSHAKE,
		SHIFT,
		WAIT_DONE,
		ACK
	} state_t;

	state_t state;
	logic write_q;
	logic [$clog2(ADDR_W)-1:0] bit_cnt;
	addr_t addr_q;
	data_t data_q;

	// Control path.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			write_q <= 1'b0;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					// Wait for the previous grant to clear.
					if (req && !bus_gnt)
					begin
						write_q <= write;
						state <= ARB;
					end
				end
				ARB:
				begin
					if (bus_gnt)
						state <= HANDSHAKE;
				end
				HANDSHAKE:
				begin
					if (link.ready)
					begin
						bit_cnt <= '0;
						state <= SHIFT;
					end
				end
				SHIFT:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == ADDR_W - 1)
						state <= WAIT_DONE;
				end
				WAIT_DONE:
				begin
					if (link.done)
						state <= ACK;
				end
				ACK:
				begin
					if (!req)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Payload shift registers, LSB first on the wire.
	always_ff @(posedge clk)
	begin
		if (state == IDLE && req)
		begin
			addr_q <= addr;
			data_q <= wdata;
		end
		else if (state == SHIFT)
		begin
			addr_q <= {1'b0, addr_q[ADDR_W-1:1]};
			data_q <= {1'b0, data_q[DATA_W-1:1]};
		end
		// Read bits arrive LSB first until done.
		if (state == WAIT_DONE && !link.done && !write_q)
			rdata <= {link.rx_data, rdata[DATA_W-1:1]};
	end

	assign bus_req = (state == ARB) || (state == HANDSHAKE) ||
		(state == SHIFT) || (state == WAIT_DONE);
	assign ack = (state == ACK);

	assign link.valid = (state == HANDSHAKE);
	assign link.write_en = write_q;
	assign link.tx_address = (state == SHIFT) & addr_q[0];
	assign link.tx_data = (state == SHIFT) & data_q[0];

endmodule

`default_nettype wire

/* hdl/serial_bus_pkg.sv */
`default_nettype none

package serial_bus_pkg;

	// Link payload widths.
	localparam int ADDR_W = 12;
	localparam int DATA_W = 8;

	// Address bit 11 picks the slave.
	localparam int SEL_BIT = 11;

	// Each slave holds 256 bytes, indexed by address bits 7:0.
	localparam int MEM_DEPTH = 256;
	localparam int MEM_IDX_W = 8;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

/* hdl/serial_bus_top.sv */
`timescale 1ns/100ps
`default_nettype none

module serial_bus_top (
	input wire logic clk,
	input wire logic reset,
	input wire logic m0_req,
	input wire logic m0_write,
	input serial_bus_pkg::addr_t m0_addr,
	input serial_bus_pkg::data_t m0_wdata,
	output logic m0_ack,
	output serial_bus_pkg::data_t m0_rdata,
	input wire logic m1_req,
	input wire logic m1_write,
	input serial_bus_pkg::addr_t m1_addr,
	input serial_bus_pkg::data_t m1_wdata,
	output logic m1_ack,
	output serial_bus_pkg::data_t m1_rdata
);

	logic bus_req0;
	logic bus_req1;
	logic bus_gnt0;
	logic bus_gnt1;

	serial_link_if m_link0 ();
	serial_link_if m_link1 ();
	serial_link_if s_link0 ();
	serial_link_if s_link1 ();

	master_port u_master0 (
		.clk (clk),
		.reset (reset),
		.req (m0_req),
		.write (m0_write),
		.addr (m0_addr),
		.wdata (m0_wdata),
		.ack (m0_ack),
		.rdata (m0_rdata),
		.bus_req (bus_req0),
		.bus_gnt (bus_gnt0),
		.link (m_link0.master)
	);

	master_port u_master1 (
		.clk (clk),
		.reset (reset),
		.req (m1_req),
		.write (m1_write),
		.addr (m1_addr),
		.wdata (m1_wdata),
		.ack (m1_ack),
		.rdata (m1_rdata),
		.bus_req (bus_req1),
		.bus_gnt (bus_gnt1),
		.link (m_link1.master)
	);

	bus_arbiter u_arbiter (
		.clk (clk),
		.reset (reset),
		.bus_req0 (bus_req0),
		.bus_req1 (bus_req1),
		.bus_gnt0 (bus_gnt0),
		.bus_gnt1 (bus_gnt1),
		.m_link0 (m_link0.slave),
		.m_link1 (m_link1.slave),
		.s_link0 (s_link0.master),
		.s_link1 (s_link1.master)
	);

	slave_memory #(.SLAVE_ID(1'b0)) u_slave0 (
		.clk (clk),
		.reset (reset),
		.link (s_link0.slave)
	);

	slave_memory #(.SLAVE_ID(1'b1)) u_slave1 (
		.clk (clk),
		.reset (reset),
		.link (s_link1.slave)
	);

endmodule

`default_nettype wire

/* hdl/serial_link_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface serial_link_if;

	// Request side.
	logic valid;
	logic write_en;
	logic tx_address;
	logic tx_data;

	// Response side.
	logic ready;
	logic rx_data;
	logic done;

	modport master (
		output valid, write_en, tx_address, tx_data,
		input ready, rx_data, done
	);

	modport slave (
		input valid, write_en, tx_address, tx_data,
		output ready, rx_data, done
	);

endinterface

`default_nettype wire

/* hdl/slave_in_port.sv */
`timescale 1ns/100ps
`default_nettype none

module slave_in_port (
	input wire logic clk,
	input wire logic reset,
	serial_link_if.slave link,
	output serial_bus_pkg::addr_t address,
	output serial_bus_pkg::data_t data,
	output logic rx_done
);
	import serial_bus_pkg::*;

	// Zero is idle and 1 to 12 count the address bit cycles.
	logic [$clog2(ADDR_W+1)-1:0] addr_state;
	logic idle;
	logic handshake;

	// Stay busy through the cycle that reports the address.
	assign idle = (addr_state == '0) & ~rx_done;
	assign link.ready = idle;
	assign handshake = link.valid & idle;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			addr_state <= '0;
			rx_done <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0;
			if (addr_state == '0)
			begin
				if (handshake)
					addr_state <= addr_state + 1'b1;
			end
			else if (addr_state == ADDR_W)
			begin
				addr_state <= '0;
				rx_done <= 1'b1;
			end
			else
				addr_state <= addr_state + 1'b1;
		end
	end

	// Bits arrive LSB first and shift down from the top.
	always_ff @(posedge clk)
	begin
		if (addr_state != '0)
		begin
			address <= {link.tx_address, address[ADDR_W-1:1]};
			// Data rides along the first 8 address cycles.
			if (addr_state <= DATA_W)
				data <= {link.tx_data, data[DATA_W-1:1]};
		end
	end

endmodule

`default_nettype wire

/* hdl/slave_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module slave_memory #(
	parameter logic [$clog2(serial_bus_pkg::NUM_SLAVES)-1:0] SLAVE_ID = '0
) (
	input wire logic clk,
	input wire logic reset,
	serial_link_if.slave link
);
	import serial_bus_pkg::*;

	data_t mem [MEM_DEPTH];

	serial_link_if in_link ();

	addr_t address;
	data_t data;
	logic rx_done;

	logic selected;
	logic write_done;
	logic read_start;
	data_t rd_byte;

	logic rd_busy;
	logic [$clog2(DATA_W)-1:0] bit_cnt;
	logic [DATA_W-2:0] shift_q;

	// The input port sees the link only while no read is returning.
	assign in_link.valid = link.valid & ~rd_busy;
	assign in_link.tx_address = link.tx_address;
	assign in_link.tx_data = link.tx_data;
	assign link.ready = in_link.ready & ~rd_busy;

	slave_in_port u_in_port (
		.clk (clk),
		.reset (reset),
		.link (in_link.slave),
		.address (address),
		.data (data),
		.rx_done (rx_done)
	);

	// Decode.
	assign selected = (address[SEL_BIT] == SLAVE_ID);
	assign write_done = rx_done & selected & link.write_en;
	assign read_start = rx_done & selected & ~link.write_en;
	assign rd_byte = mem[address[MEM_IDX_W-1:0]];

	always_ff @(posedge clk)
	begin
		if (write_done)
			mem[address[MEM_IDX_W-1:0]] <= data;
	end

	// Bit 0 goes out with rx_done and bits 1 to 7 come from the shifter.
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_busy <= 1'b0;
			bit_cnt <= '0;
			shift_q <= '0;
		end
		else if (read_start)
		begin
			rd_busy <= 1'b1;
			bit_cnt <= '0;
			shift_q <= rd_byte[DATA_W-1:1];
		end
		else if (rd_busy)
		begin
			shift_q <= shift_q >> 1;
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == DATA_W - 1)
				rd_busy <= 1'b0;
		end
	end

	// Both stay zero unless this slave was addressed.
	assign link.rx_data = read_start ? rd_byte[0] : shift_q[0];
	assign link.done = write_done | (rd_busy & (bit_cnt == DATA_W - 1));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the serial bus testbench with Verilator and runs it.
# A failing check ends the run through $fatal, which gives a nonzero exit status.
set -e
cd "$(dirname "$0")"
verilator --binary -j 0 --top-module tb_serial_bus -f verilog.f -o tb_serial_bus
./obj_dir/tb_serial_bus

/* verilog.f */
hdl/serial_bus_pkg.sv
hdl/serial_link_if.sv
hdl/slave_in_port.sv
hdl/slave_memory.sv
hdl/master_port.sv
hdl/bus_arbiter.sv
hdl/serial_bus_top.sv
bench/tb_serial_bus.sv
